/* Makefile */
# Verilator build and run for the background renderer

VERILATOR ?= verilator
TOP       ?= bg_renderer_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/bg_defines.svh */
//----------------------------------------
// background scene geometry and colours
//----------------------------------------
`ifndef BG_DEFINES_SVH
`define BG_DEFINES_SVH

// visible screen
`define BG_H_PIXELS 1024
`define BG_V_PIXELS 768
`define BG_COORD_W 11
`define BG_RGB_W 12

// platform rectangles, bounds are exclusive
`define BG_P1_X_START 80
`define BG_P1_X_END 280
`define BG_P1_Y_START 200
`define BG_P1_Y_END 215
`define BG_P2_X_START 350
`define BG_P2_X_END 550
`define BG_P2_Y_START 320
`define BG_P2_Y_END 335
`define BG_P3_X_START 300
`define BG_P3_X_END 500
`define BG_P3_Y_START 480
`define BG_P3_Y_END 495
`define BG_P4_X_START 700
`define BG_P4_X_END 900
`define BG_P4_Y_START 150
`define BG_P4_Y_END 165

// grass and fence
`define BG_GRASS_TOP 550
`define BG_FENCE_TOP 300
`define BG_FENCE_RIGHT 500
`define BG_FENCE_POST_STEP 100

// house
`define BG_HOUSE_LEFT 650
`define BG_HOUSE_TOP 250
`define BG_ROOF_BOTTOM 300
`define BG_WIN_LEFT 705
`define BG_WIN_RIGHT 825
`define BG_WIN_TOP 330
`define BG_WIN_BOTTOM 450
`define BG_WIN_MID_X 765
`define BG_WIN_MID_Y 390
`define BG_DOOR_LEFT 910
`define BG_DOOR_TOP 350
`define BG_HANDLE_X 915
`define BG_HANDLE_X_END 925
`define BG_HANDLE_Y 448

// palette, 4 bits per channel
`define BG_COLOR_BLACK 12'h000
`define BG_COLOR_PLATFORM 12'h111
`define BG_COLOR_GREEN 12'h0b0
`define BG_COLOR_BROWN 12'h852
`define BG_COLOR_ROOF 12'ha10
`define BG_COLOR_WALL 12'hccc
`define BG_COLOR_WINDOW 12'hddf
`define BG_COLOR_DOOR 12'h741
`define BG_COLOR_HANDLE 12'heee
`define BG_COLOR_SKY 12'h0af

`endif

/* hdl/bg_pkg.sv */
//----------------------------------------
// background renderer types
//----------------------------------------
`include "bg_defines.svh"

package bg_pkg;

    // raster position, hcount or vcount
    typedef logic [`BG_COORD_W-1:0] pixel_coord_t;

    // 4:4:4 colour
    typedef logic [`BG_RGB_W-1:0] rgb_t;

    // what a pixel shows, open = not yet resolved
    typedef enum logic [3:0] {
        REGION_BLACK,
        REGION_PLATFORM,
        REGION_OPEN,
        REGION_GRASS,
        REGION_FENCE,
        REGION_ROOF,
        REGION_WALL,
        REGION_WINDOW,
        REGION_DOOR,
        REGION_HANDLE,
        REGION_SKY
    } scene_region_t;

endpackage

/* hdl/bg_renderer.sv */
//----------------------------------------
// game background renderer, three-stage
// pixel colour pipeline
//----------------------------------------
`timescale 1ns/1ps

module bg_renderer (
    input  logic                 clk,
    input  logic                 rst,
    input  bg_pkg::pixel_coord_t hcount,
    input  bg_pkg::pixel_coord_t vcount,
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 hblnk,
    input  logic                 vblnk,
    output bg_pkg::pixel_coord_t hcount_out,
    output bg_pkg::pixel_coord_t vcount_out,
    output logic                 hsync_out,
    output logic                 vsync_out,
    output logic                 hblnk_out,
    output logic                 vblnk_out,
    output bg_pkg::rgb_t         rgb
);

    // stage 1 -> stage 2
    vga_stage_if s1 ();
    // stage 2 -> stage 3
    vga_stage_if s2 ();

    platform_match platform_match_inst (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .out    (s1.src)
    );

    landscape_classify landscape_classify_inst (
        .clk (clk),
        .rst (rst),
        .in  (s1.snk),
        .out (s2.src)
    );

    palette_map palette_map_inst (
        .clk        (clk),
        .rst        (rst),
        .in         (s2.snk),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb        (rgb)
    );

endmodule

/* hdl/landscape_classify.sv */
//----------------------------------------
// stage 2: resolves open pixels into
// grass, fence, house or sky
//----------------------------------------
`timescale 1ns/1ps
`include "bg_defines.svh"

module landscape_classify (
    input  logic     clk,
    input  logic     rst,
    vga_stage_if.snk in,
    vga_stage_if.src out
);
    import bg_pkg::*;

    logic          in_grass;
    logic          in_fence;
    logic          fence_line;
    logic          in_house;
    logic          house_outline;
    logic          in_window;
    logic          window_line;
    logic          in_door;
    logic          door_outline;
    logic          on_handle;
    scene_region_t region_nxt;

    // grass runs to the bottom of the screen
    assign in_grass = in.vcount >= `BG_GRASS_TOP;

    assign in_fence = (in.vcount >= `BG_FENCE_TOP) && (in.vcount < `BG_GRASS_TOP) &&
                      (in.hcount <= `BG_FENCE_RIGHT);
    // bottom rail and posts
    assign fence_line = (in.vcount == `BG_GRASS_TOP - 1) || (in.hcount == 1) ||
                        ((in.hcount % `BG_FENCE_POST_STEP) == 0);

    assign in_house = (in.vcount >= `BG_HOUSE_TOP) && (in.vcount < `BG_GRASS_TOP) &&
                      (in.hcount >= `BG_HOUSE_LEFT);
    assign house_outline = (in.hcount == `BG_HOUSE_LEFT) || (in.vcount == `BG_ROOF_BOTTOM);

    assign in_window = (in.hcount >= `BG_WIN_LEFT) && (in.hcount <= `BG_WIN_RIGHT) &&
                       (in.vcount >= `BG_WIN_TOP) && (in.vcount <= `BG_WIN_BOTTOM);
    // frame plus the two mullions
    assign window_line = (in.hcount == `BG_WIN_LEFT) || (in.hcount == `BG_WIN_RIGHT) ||
                         (in.vcount == `BG_WIN_TOP) || (in.vcount == `BG_WIN_BOTTOM) ||
                         (in.hcount == `BG_WIN_MID_X) || (in.vcount == `BG_WIN_MID_Y);

    assign in_door = (in.hcount >= `BG_DOOR_LEFT) && (in.vcount >= `BG_DOOR_TOP);
    assign door_outline = (in.hcount == `BG_DOOR_LEFT) || (in.vcount == `BG_DOOR_TOP);

    // short horizontal bar with a stub hanging down on the left
    assign on_handle =
        ((in.vcount >= `BG_HANDLE_Y) && (in.vcount <= `BG_HANDLE_Y + 1) &&
         (in.hcount >= `BG_HANDLE_X) && (in.hcount <= `BG_HANDLE_X_END)) ||
        ((in.vcount >= `BG_HANDLE_Y) && (in.vcount <= `BG_HANDLE_Y + 3) &&
         (in.hcount == `BG_HANDLE_X));

    always_comb begin
        region_nxt = in.region;
        if (in.region == REGION_OPEN) begin
            if (in_grass) begin
                region_nxt = (in.vcount == `BG_GRASS_TOP) ? REGION_BLACK : REGION_GRASS;
            end else if (in_fence) begin
                region_nxt = fence_line ? REGION_BLACK : REGION_FENCE;
            end else if (in_house) begin
                if (in.vcount < `BG_ROOF_BOTTOM) begin
                    region_nxt = REGION_ROOF;
                end else if (house_outline) begin
                    region_nxt = REGION_BLACK;
                end else if (in_window) begin
                    region_nxt = window_line ? REGION_BLACK : REGION_WINDOW;
                end else if (in_door) begin
                    if (door_outline) begin
                        region_nxt = REGION_BLACK;
                    end else if (on_handle) begin
                        region_nxt = REGION_HANDLE;
                    end else begin
                        region_nxt = REGION_DOOR;
                    end
                end else begin
                    region_nxt = REGION_WALL;
                end
            end else begin
                region_nxt = REGION_SKY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.region <= REGION_BLACK;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            out.region <= region_nxt;
        end
    end

endmodule

/* hdl/palette_map.sv */
//----------------------------------------
// stage 3: region tag to colour, output
// register
//----------------------------------------
`timescale 1ns/1ps
`include "bg_defines.svh"

module palette_map (
    input  logic                 clk,
    input  logic                 rst,
    vga_stage_if.snk             in,
    output bg_pkg::pixel_coord_t hcount_out,
    output bg_pkg::pixel_coord_t vcount_out,
    output logic                 hsync_out,
    output logic                 vsync_out,
    output logic                 hblnk_out,
    output logic                 vblnk_out,
    output bg_pkg::rgb_t         rgb
);
    import bg_pkg::*;

    rgb_t rgb_nxt;

    always_comb begin
        case (in.region)
            REGION_PLATFORM: rgb_nxt = `BG_COLOR_PLATFORM;
            REGION_GRASS:    rgb_nxt = `BG_COLOR_GREEN;
            REGION_FENCE:    rgb_nxt = `BG_COLOR_BROWN;
            REGION_ROOF:     rgb_nxt = `BG_COLOR_ROOF;
            REGION_WALL:     rgb_nxt = `BG_COLOR_WALL;
            REGION_WINDOW:   rgb_nxt = `BG_COLOR_WINDOW;
            REGION_DOOR:     rgb_nxt = `BG_COLOR_DOOR;
            REGION_HANDLE:   rgb_nxt = `BG_COLOR_HANDLE;
            REGION_SKY:      rgb_nxt = `BG_COLOR_SKY;
            // black, and open which stage 2 never passes on
            default:         rgb_nxt = `BG_COLOR_BLACK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb        <= '0;
        end else begin
            hcount_out <= in.hcount;
            vcount_out <= in.vcount;
            hsync_out  <= in.hsync;
            vsync_out  <= in.vsync;
            hblnk_out  <= in.hblnk;
            vblnk_out  <= in.vblnk;
            rgb        <= rgb_nxt;
        end
    end

endmodule

/* hdl/platform_match.sv */
//----------------------------------------
// stage 1: tags blanking, border and
// platform pixels
//----------------------------------------
`timescale 1ns/1ps
`include "bg_defines.svh"

module platform_match (
    input  logic               clk,
    input  logic               rst,
    input  bg_pkg::pixel_coord_t hcount,
    input  bg_pkg::pixel_coord_t vcount,
    input  logic               hsync,
    input  logic               vsync,
    input  logic               hblnk,
    input  logic               vblnk,
    vga_stage_if.src           out
);
    import bg_pkg::*;

    logic          on_border;
    logic          on_platform;
    scene_region_t region_nxt;

    // strictly inside, the bounds themselves fall through
    function automatic logic in_rect(
        input pixel_coord_t h,
        input pixel_coord_t v,
        input pixel_coord_t x0,
        input pixel_coord_t x1,
        input pixel_coord_t y0,
        input pixel_coord_t y1
    );
        return (h > x0) && (h < x1) && (v > y0) && (v < y1);
    endfunction

    assign on_border = (hcount == 0) || (hcount == `BG_H_PIXELS - 1) ||
                       (vcount == 0) || (vcount == `BG_V_PIXELS - 1);

    assign on_platform =
        in_rect(hcount, vcount, `BG_P1_X_START, `BG_P1_X_END, `BG_P1_Y_START, `BG_P1_Y_END) ||
        in_rect(hcount, vcount, `BG_P2_X_START, `BG_P2_X_END, `BG_P2_Y_START, `BG_P2_Y_END) ||
        in_rect(hcount, vcount, `BG_P3_X_START, `BG_P3_X_END, `BG_P3_Y_START, `BG_P3_Y_END) ||
        in_rect(hcount, vcount, `BG_P4_X_START, `BG_P4_X_END, `BG_P4_Y_START, `BG_P4_Y_END);

    always_comb begin
        if (hblnk || vblnk || on_border) begin
            region_nxt = REGION_BLACK;
        end else if (on_platform) begin
            region_nxt = REGION_PLATFORM;
        end else begin
            region_nxt = REGION_OPEN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.region <= REGION_BLACK;
        end else begin
            out.hcount <= hcount;
            out.vcount <= vcount;
            out.hsync  <= hsync;
            out.vsync  <= vsync;
            out.hblnk  <= hblnk;
            out.vblnk  <= vblnk;
            out.region <= region_nxt;
        end
    end

endmodule

/* hdl/vga_stage_if.sv */
//----------------------------------------
// one pixel's timing and region tag
//----------------------------------------
`timescale 1ns/1ps

interface vga_stage_if;
    import bg_pkg::*;

    pixel_coord_t  hcount;
    pixel_coord_t  vcount;
    logic          hsync;
    logic          vsync;
    logic          hblnk;
    logic          vblnk;
    scene_region_t region;

    // driving stage
    modport src (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, region
    );

    // receiving stage
    modport snk (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, region
    );

endinterface

/* sources.f */
+incdir+hdl
hdl/bg_pkg.sv
hdl/vga_stage_if.sv
hdl/platform_match.sv
hdl/landscape_classify.sv
hdl/palette_map.sv
hdl/bg_renderer.sv
testbench/bg_renderer_chk.sv
testbench/bg_renderer_tb.sv

/* testbench/bg_renderer_chk.sv */
//----------------------------------------
// output timing checks for the renderer
//----------------------------------------
`timescale 1ns/1ps

module bg_renderer_chk (
    input logic                 clk,
    input logic                 rst,
    input bg_pkg::pixel_coord_t hcount,
    input bg_pkg::pixel_coord_t vcount,
    input logic                 hsync,
    input logic                 vsync,
    input logic                 hblnk,
    input logic                 vblnk,
    input bg_pkg::pixel_coord_t hcount_out,
    input bg_pkg::pixel_coord_t vcount_out,
    input logic                 hsync_out,
    input logic                 vsync_out,
    input logic                 hblnk_out,
    input logic                 vblnk_out,
    input bg_pkg::rgb_t         rgb
);

    // cycles since reset, saturates at the pipeline depth
    logic [1:0] warm;

    always_ff @(posedge clk) begin
        if (rst) begin
            warm <= 2'd0;
        end else if (warm != 2'd3) begin
            warm <= warm + 2'd1;
        end
    end

    // inputs of three edges ago
    assert property (@(posedge clk) disable iff (rst)
        (warm == 2'd3) |-> (hcount_out == $past(hcount, 3)) && (vcount_out == $past(vcount, 3)))
    else $error("coordinates not delayed by three cycles");

    assert property (@(posedge clk) disable iff (rst)
        (warm == 2'd3) |->
        ({hsync_out, vsync_out, hblnk_out, vblnk_out} == $past({hsync, vsync, hblnk, vblnk}, 3)))
    else $error("sync or blank flags not delayed by three cycles");

    assert property (@(posedge clk) disable iff (rst)
        (hblnk_out || vblnk_out) |-> (rgb == '0))
    else $error("colour driven during blanking");

endmodule

/* testbench/bg_renderer_tb.sv */
//----------------------------------------
// testbench for the background renderer
//----------------------------------------
`timescale 1ns/1ps
`include "bg_defines.svh"

module bg_renderer_tb;
    import bg_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;
    localparam int N_SPECIAL = 64 * 4;
    localparam int N_PLATFORM = 4 * 6;
    localparam int SWEEP_LEN = 1056;
    localparam int N_SWEEP_ROWS = 8;
    localparam int N_RANDOM = 4000;
    localparam int N_DRAIN = 3;
    localparam int TEST_CYCLES = RESET_CYCLES + N_SPECIAL + N_PLATFORM +
                                 N_SWEEP_ROWS * SWEEP_LEN + N_RANDOM + N_DRAIN;
    localparam int MARGIN_CYCLES = 200;

    // exclusive platform bounds
    localparam int PX0[4] = '{`BG_P1_X_START, `BG_P2_X_START, `BG_P3_X_START, `BG_P4_X_START};
    localparam int PX1[4] = '{`BG_P1_X_END, `BG_P2_X_END, `BG_P3_X_END, `BG_P4_X_END};
    localparam int PY0[4] = '{`BG_P1_Y_START, `BG_P2_Y_START, `BG_P3_Y_START, `BG_P4_Y_START};
    localparam int PY1[4] = '{`BG_P1_Y_END, `BG_P2_Y_END, `BG_P3_Y_END, `BG_P4_Y_END};
    localparam int SWEEP_ROWS[8] = '{549, 550, 600, 280, 300, 390, 449, 500};

    typedef struct packed {
        pixel_coord_t h;
        pixel_coord_t v;
        logic         hs;
        logic         vs;
        logic         hb;
        logic         vb;
        rgb_t         rgb;
    } expect_t;

    logic         clk;
    logic         rst;
    pixel_coord_t hcount;
    pixel_coord_t vcount;
    logic         hsync;
    logic         vsync;
    logic         hblnk;
    logic         vblnk;
    pixel_coord_t hcount_out;
    pixel_coord_t vcount_out;
    logic         hsync_out;
    logic         vsync_out;
    logic         hblnk_out;
    logic         vblnk_out;
    rgb_t         rgb;
    logic [31:0]  rng_state;
    expect_t      expected_q[$];

    bg_renderer bg_renderer_inst (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb        (rgb)
    );

    bind bg_renderer bg_renderer_chk bg_renderer_chk_inst (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb        (rgb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference scene, rules in priority order
    function automatic rgb_t colour_of(input int h, input int v, input logic hb, input logic vb);
        if (hb || vb || h == 0 || v == 0 || h == `BG_H_PIXELS - 1 || v == `BG_V_PIXELS - 1)
            return `BG_COLOR_BLACK;
        for (int i = 0; i < 4; i++) begin
            if (h > PX0[i] && h < PX1[i] && v > PY0[i] && v < PY1[i])
                return `BG_COLOR_PLATFORM;
        end
        if (v >= `BG_GRASS_TOP)
            return (v == `BG_GRASS_TOP) ? `BG_COLOR_BLACK : `BG_COLOR_GREEN;
        if (v >= `BG_FENCE_TOP && h <= `BG_FENCE_RIGHT) begin
            if (v == `BG_GRASS_TOP - 1 || h == 1 || h % `BG_FENCE_POST_STEP == 0)
                return `BG_COLOR_BLACK;
            return `BG_COLOR_BROWN;
        end
        if (v >= `BG_HOUSE_TOP && h >= `BG_HOUSE_LEFT) begin
            if (v < `BG_ROOF_BOTTOM)
                return `BG_COLOR_ROOF;
            if (h == `BG_HOUSE_LEFT || v == `BG_ROOF_BOTTOM)
                return `BG_COLOR_BLACK;
            if (h >= `BG_WIN_LEFT && h <= `BG_WIN_RIGHT && v >= `BG_WIN_TOP &&
                v <= `BG_WIN_BOTTOM) begin
                if (h == `BG_WIN_LEFT || h == `BG_WIN_RIGHT || h == `BG_WIN_MID_X ||
                    v == `BG_WIN_TOP || v == `BG_WIN_BOTTOM || v == `BG_WIN_MID_Y)
                    return `BG_COLOR_BLACK;
                return `BG_COLOR_WINDOW;
            end
            if (h >= `BG_DOOR_LEFT && v >= `BG_DOOR_TOP) begin
                if (h == `BG_DOOR_LEFT || v == `BG_DOOR_TOP)
                    return `BG_COLOR_BLACK;
                if (v >= `BG_HANDLE_Y && v <= `BG_HANDLE_Y + 1 && h >= `BG_HANDLE_X &&
                    h <= `BG_HANDLE_X_END)
                    return `BG_COLOR_HANDLE;
                if (v >= `BG_HANDLE_Y && v <= `BG_HANDLE_Y + 3 && h == `BG_HANDLE_X)
                    return `BG_COLOR_HANDLE;
                return `BG_COLOR_DOOR;
            end
            return `BG_COLOR_WALL;
        end
        return `BG_COLOR_SKY;
    endfunction

    task automatic report_failure(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_outputs();
        expect_t e;
        e = expected_q.pop_front();
        assert ({hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out} ===
                {e.h, e.v, e.hs, e.vs, e.hb, e.vb})
        else report_failure($sformatf("timing out %0d,%0d flags %b%b%b%b, expected %0d,%0d",
                                      hcount_out, vcount_out, hsync_out, vsync_out,
                                      hblnk_out, vblnk_out, e.h, e.v));
        assert (rgb === e.rgb)
        else report_failure($sformatf("pixel (%0d,%0d) rgb %h, expected %h",
                                      e.h, e.v, rgb, e.rgb));
    endtask

    // one pixel per clock, checked three pixels later
    task automatic drive_pixel(input int h, input int v, input logic hs, input logic vs,
                               input logic hb, input logic vb);
        expect_t e;
        hcount = pixel_coord_t'(h);
        vcount = pixel_coord_t'(v);
        hsync = hs;
        vsync = vs;
        hblnk = hb;
        vblnk = vb;
        e.h = pixel_coord_t'(h);
        e.v = pixel_coord_t'(v);
        e.hs = hs;
        e.vs = vs;
        e.hb = hb;
        e.vb = vb;
        e.rgb = colour_of(h, v, hb, vb);
        expected_q.push_back(e);
        @(posedge clk);
        #1;
        check_outputs();
    endtask

    task automatic sweep_row(input int v);
        for (int h = 0; h < SWEEP_LEN; h++) begin
            drive_pixel(h, v, h >= 1032 && h < 1048, 1'b0, h >= `BG_H_PIXELS, 1'b0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        logic [31:0] r;
        expect_t     cleared;
        rst = 1'b1;
        hcount = '0;
        vcount = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        hblnk = 1'b0;
        vblnk = 1'b0;
        rng_state = 32'd22;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        assert ({hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out, rgb} === '0)
        else report_failure("outputs not cleared by reset");
        rst = 1'b0;
        // the two stages behind the output still hold reset values
        cleared = '0;
        expected_q.push_back(cleared);
        expected_q.push_back(cleared);

        // blanking and the screen border
        for (int i = 0; i < 64; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            drive_pixel(int'(r[9:0]), int'(r[19:10]) % 768, r[20], r[21], 1'b1, 1'b0);
            drive_pixel(int'(r[9:0]), int'(r[19:10]) % 768, r[20], r[21], 1'b0, 1'b1);
            drive_pixel(r[22] ? 1023 : 0, int'(r[19:10]) % 768, 1'b0, 1'b0, 1'b0, 1'b0);
            drive_pixel(int'(r[9:0]), r[23] ? 767 : 0, 1'b0, 1'b0, 1'b0, 1'b0);
        end

        // just inside and exactly on each platform bound
        for (int i = 0; i < 4; i++) begin
            drive_pixel(PX0[i] + 1, PY0[i] + 1, 1'b0, 1'b0, 1'b0, 1'b0);
            drive_pixel(PX1[i] - 1, PY1[i] - 1, 1'b0, 1'b0, 1'b0, 1'b0);
            drive_pixel(PX0[i], PY0[i] + 1, 1'b0, 1'b0, 1'b0, 1'b0);
            drive_pixel(PX1[i], PY1[i] - 1, 1'b0, 1'b0, 1'b0, 1'b0);
            drive_pixel(PX0[i] + 1, PY0[i], 1'b0, 1'b0, 1'b0, 1'b0);
            drive_pixel(PX0[i] + 1, PY1[i], 1'b0, 1'b0, 1'b0, 1'b0);
        end

        // fence, grass and house rows
        for (int i = 0; i < N_SWEEP_ROWS; i++) begin
            sweep_row(SWEEP_ROWS[i]);
        end

        // mostly on screen, a few beyond the visible edge
        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            drive_pixel(int'(r[10:0]) % 1100, int'(r[21:11]) % 800, r[22], r[23],
                        r[26:24] == 3'd0, r[29:27] == 3'd0);
        end

        for (int i = 0; i < N_DRAIN; i++) begin
            drive_pixel(0, 0, 1'b0, 1'b0, 1'b1, 1'b1);
        end

        $display("Done: no errors");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule
